// ==== logic/ecc_mem_consts.svh ====
// Size constants for the SECDED memory: data, check and codeword widths, address width, depth
`ifndef ECC_MEM_CONSTS_SVH
`define ECC_MEM_CONSTS_SVH

// Payload word seen by the bus master
`define ECC_DATA_W 32

// Six Hamming check bits plus one overall parity bit
`define ECC_CHECK_W 7

// Stored codeword, data plus check bits
`define ECC_CODE_W 39

// Word address into the codeword array
`define ECC_ADDR_W 8

// Number of codewords held by the RAM
`define ECC_DEPTH 256

`endif

// ==== logic/ecc_mem_pkg.sv ====
// Types shared by the ECC memory design: front-end states, ECC read outcomes, memory opcodes
package ecc_mem_pkg;

  // Wishbone front-end FSM states
  // IDLE accepts a new cycle, WAIT_RSP waits for the memory, ACK lets the strobe drop
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    WAIT_RSP = 2'd1,
    ACK      = 2'd2
  } fe_state_e;

  // Outcome of a SECDED check on one read
  typedef enum logic [1:0] {
    ECC_OK            = 2'd0,
    ECC_CORRECTED     = 2'd1,
    ECC_UNCORRECTABLE = 2'd2
  } ecc_status_e;

  // Operation carried by a memory request
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

endpackage

// ==== logic/mem_req_if.sv ====
// Memory request interface between pipeline stages, with source and destination modports
`timescale 1ns/1ps
`include "ecc_mem_consts.svh"

interface mem_req_if;

  // Single-cycle request strobe, there is no handshake back to the source
  logic                       req;
  ecc_mem_pkg::mem_op_e       op;
  logic [`ECC_ADDR_W-1:0]     addr;
  // Raw write data, filled in by the front end
  logic [`ECC_DATA_W-1:0]     wdata;
  // Encoded write codeword, filled in by the encoder stage
  logic [`ECC_CODE_W-1:0]     code;

  // The stage that produces the request
  modport src (
    output req,
    output op,
    output addr,
    output wdata,
    output code
  );

  // The stage that consumes the request
  modport dst (
    input req,
    input op,
    input addr,
    input wdata,
    input code
  );

endinterface

// ==== logic/wb_mem_frontend.sv ====
// Wishbone classic slave FSM that issues one memory request per cycle and returns the response
`timescale 1ns/1ps
`include "ecc_mem_consts.svh"

module wb_mem_frontend (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      cyc_i,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic [`ECC_ADDR_W-1:0]    adr_i,
  input  logic [`ECC_DATA_W-1:0]    dat_i,
  output logic [`ECC_DATA_W-1:0]    dat_o,
  output logic                      ack_o,
  output logic                      err_o,
  output ecc_mem_pkg::ecc_status_e  ecc_status_o,
  mem_req_if.src                    req,
  input  logic                      rsp_valid_i,
  input  logic [`ECC_DATA_W-1:0]    rsp_data_i,
  input  ecc_mem_pkg::ecc_status_e  rsp_status_i
);

  ecc_mem_pkg::fe_state_e   state_q;
  ecc_mem_pkg::mem_op_e     op_q;
  ecc_mem_pkg::ecc_status_e status_q;
  logic                     req_q;
  logic [`ECC_ADDR_W-1:0]   addr_q;
  logic [`ECC_DATA_W-1:0]   wdata_q;
  logic [1:0]               wcnt_q;
  logic                     done;
  logic                     rsp_bad;

  // A write is done once the encoder and RAM stages have both seen it, two edges after issue
  // A read is done when the decoder presents its registered result
  assign done    = (op_q == ecc_mem_pkg::MEM_WRITE) ? (wcnt_q == 2'd2) : rsp_valid_i;
  assign rsp_bad = (rsp_status_i == ecc_mem_pkg::ECC_UNCORRECTABLE);

  // Responses are decoded from the state so that a read completes in the same cycle
  // the decoder result is visible, four edges after the strobe was taken
  assign ack_o = (state_q == ecc_mem_pkg::WAIT_RSP) && done &&
                 !((op_q == ecc_mem_pkg::MEM_READ) && rsp_bad);
  assign err_o = (state_q == ecc_mem_pkg::WAIT_RSP) && done &&
                 (op_q == ecc_mem_pkg::MEM_READ) && rsp_bad;

  // The decoder holds its last result until the next read completes
  // Status switches to the held copy once the result is gone, so writes report clean
  assign dat_o        = rsp_data_i;
  assign ecc_status_o = rsp_valid_i ? rsp_status_i : status_q;

  // Request fields towards the encoder, the codeword is not known here yet
  assign req.req   = req_q;
  assign req.op    = op_q;
  assign req.addr  = addr_q;
  assign req.wdata = wdata_q;
  assign req.code  = '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= ecc_mem_pkg::IDLE;
      op_q     <= ecc_mem_pkg::MEM_READ;
      status_q <= ecc_mem_pkg::ECC_OK;
      req_q    <= 1'b0;
      wcnt_q   <= 2'd0;
    end else begin
      // The request is a one-cycle pulse
      req_q <= 1'b0;
      case (state_q)
        ecc_mem_pkg::IDLE: begin
          if (cyc_i && stb_i) begin
            req_q   <= 1'b1;
            op_q    <= we_i ? ecc_mem_pkg::MEM_WRITE : ecc_mem_pkg::MEM_READ;
            wcnt_q  <= 2'd0;
            state_q <= ecc_mem_pkg::WAIT_RSP;
            // Writes carry no check result, report a clean status for them
            if (we_i) begin
              status_q <= ecc_mem_pkg::ECC_OK;
            end
          end
        end
        ecc_mem_pkg::WAIT_RSP: begin
          if (op_q == ecc_mem_pkg::MEM_WRITE) begin
            wcnt_q <= wcnt_q + 2'd1;
          end
          if (rsp_valid_i) begin
            status_q <= rsp_status_i;
          end
          if (done) begin
            state_q <= ecc_mem_pkg::ACK;
          end
        end
        // Master still holds its strobe here, it is ignored for one cycle
        ecc_mem_pkg::ACK: state_q <= ecc_mem_pkg::IDLE;
        default: state_q <= ecc_mem_pkg::IDLE;
      endcase
    end
  end

  // Address and write data of the cycle taken in IDLE
  always_ff @(posedge clk_i) begin
    if ((state_q == ecc_mem_pkg::IDLE) && cyc_i && stb_i) begin
      addr_q  <= adr_i;
      wdata_q <= dat_i;
    end
  end

endmodule

// ==== logic/secded_encoder.sv ====
// Pipeline stage that adds Hamming SECDED check bits to write data and forwards the request
`timescale 1ns/1ps
`include "ecc_mem_consts.svh"

module secded_encoder (
  input  logic    clk_i,
  input  logic    arst_n_i,
  mem_req_if.dst  up,
  mem_req_if.src  down
);

  localparam int HammingW = `ECC_CHECK_W - 1;

  logic [`ECC_CODE_W-1:0] enc_code;
  logic                   req_q;
  ecc_mem_pkg::mem_op_e   op_q;
  logic [`ECC_ADDR_W-1:0] addr_q;
  logic [`ECC_DATA_W-1:0] wdata_q;
  logic [`ECC_CODE_W-1:0] code_q;

  // Codeword bit k holds 1-based Hamming position k+1, bit 38 holds overall parity
  always_comb begin
    int unsigned di;
    enc_code = '0;
    di       = 0;
    // Scatter data into every position that is not a power of two
    for (int p = 1; p < `ECC_CODE_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        enc_code[p-1] = up.wdata[di];
        di++;
      end
    end
    // Check bit i covers every position whose index has bit i set
    for (int i = 0; i < HammingW; i++) begin
      for (int p = 1; p < `ECC_CODE_W; p++) begin
        if ((((p >> i) & 1) == 1) && (p != (1 << i))) begin
          enc_code[(1 << i) - 1] = enc_code[(1 << i) - 1] ^ enc_code[p-1];
        end
      end
    end
    // Overall parity makes the whole stored word even, this is what catches double errors
    enc_code[`ECC_CODE_W-1] = ^enc_code[`ECC_CODE_W-2:0];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q <= 1'b0;
    end else begin
      req_q <= up.req;
    end
  end

  // Request payload moves one stage forward, reads carry an all-zero codeword
  always_ff @(posedge clk_i) begin
    if (up.req) begin
      op_q    <= up.op;
      addr_q  <= up.addr;
      wdata_q <= up.wdata;
      code_q  <= (up.op == ecc_mem_pkg::MEM_WRITE) ? enc_code : '0;
    end
  end

  assign down.req   = req_q;
  assign down.op    = op_q;
  assign down.addr  = addr_q;
  assign down.wdata = wdata_q;
  assign down.code  = code_q;

endmodule

// ==== logic/badbit_ram_1p.sv ====
// Single-port codeword RAM model whose read data can be corrupted by an injection mask
`timescale 1ns/1ps
`include "ecc_mem_consts.svh"

module badbit_ram_1p (
  input  logic                   clk_i,
  mem_req_if.dst                 req,
  input  logic [`ECC_CODE_W-1:0] inject_mask_i,
  output logic                   rd_valid_o,
  output logic [`ECC_CODE_W-1:0] rd_code_o
);

  // Codeword storage, contents are undefined until written
  logic [`ECC_CODE_W-1:0] mem_q [`ECC_DEPTH];
  logic [`ECC_CODE_W-1:0] rdata_q;
  logic                   rd_valid_q;

  // One access per request, read data appears one cycle after the request
  always_ff @(posedge clk_i) begin
    if (req.req) begin
      if (req.op == ecc_mem_pkg::MEM_WRITE) begin
        mem_q[req.addr] <= req.code;
      end else begin
        rdata_q <= mem_q[req.addr];
      end
    end
  end

  // The encoder holds req low during reset, so this flag is low from the first clock edge
  always_ff @(posedge clk_i) begin
    rd_valid_q <= req.req && (req.op == ecc_mem_pkg::MEM_READ);
  end

  assign rd_valid_o = rd_valid_q;

  // Each set mask bit flips that bit of the response
  // The stored word is never touched, so a later clean read sees the original contents
  assign rd_code_o = rdata_q ^ inject_mask_i;

endmodule

// ==== logic/secded_decoder.sv ====
// Pipeline stage that checks a read codeword, corrects single errors and counts corrections
`timescale 1ns/1ps
`include "ecc_mem_consts.svh"

module secded_decoder (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      rd_valid_i,
  input  logic [`ECC_CODE_W-1:0]    rd_code_i,
  output logic                      rsp_valid_o,
  output logic [`ECC_DATA_W-1:0]    rsp_data_o,
  output ecc_mem_pkg::ecc_status_e  rsp_status_o,
  output logic [15:0]               corr_count_o
);

  localparam int SynW = `ECC_CHECK_W - 1;

  logic [SynW-1:0]          syndrome;
  logic                     par_err;
  logic [`ECC_CODE_W-1:0]   fixed_code;
  logic [`ECC_DATA_W-1:0]   dec_data;
  ecc_mem_pkg::ecc_status_e dec_status;
  logic                     rsp_valid_q;
  logic [`ECC_DATA_W-1:0]   rsp_data_q;
  ecc_mem_pkg::ecc_status_e rsp_status_q;
  logic [15:0]              corr_count_q;

  always_comb begin
    int unsigned di;
    // Syndrome is the XOR of the positions of all set bits, zero for a clean word
    syndrome = '0;
    for (int p = 1; p < `ECC_CODE_W; p++) begin
      if (rd_code_i[p-1]) begin
        syndrome = syndrome ^ SynW'(p);
      end
    end
    par_err = ^rd_code_i;

    fixed_code = rd_code_i;
    if (par_err) begin
      // Odd number of flips, taken as a single error at the syndrome position
      // A zero syndrome points at the parity bit itself, which carries no data
      dec_status = ecc_mem_pkg::ECC_CORRECTED;
      for (int p = 1; p < `ECC_CODE_W; p++) begin
        if (syndrome == SynW'(p)) begin
          fixed_code[p-1] = ~rd_code_i[p-1];
        end
      end
    end else if (syndrome != '0) begin
      // Even parity with a nonzero syndrome means two bits flipped
      dec_status = ecc_mem_pkg::ECC_UNCORRECTABLE;
    end else begin
      dec_status = ecc_mem_pkg::ECC_OK;
    end

    // Gather the data bits back from the non-power-of-two positions
    dec_data = '0;
    di       = 0;
    for (int p = 1; p < `ECC_CODE_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        dec_data[di] = fixed_code[p-1];
        di++;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q  <= 1'b0;
      corr_count_q <= '0;
    end else begin
      rsp_valid_q <= rd_valid_i;
      // Saturates instead of wrapping, so a large count never looks small
      if (rd_valid_i && (dec_status == ecc_mem_pkg::ECC_CORRECTED) &&
          (corr_count_q != 16'hffff)) begin
        corr_count_q <= corr_count_q + 16'd1;
      end
    end
  end

  // Result is held until the next read completes
  always_ff @(posedge clk_i) begin
    if (rd_valid_i) begin
      rsp_data_q   <= dec_data;
      rsp_status_q <= dec_status;
    end
  end

  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_data_o   = rsp_data_q;
  assign rsp_status_o = rsp_status_q;
  assign corr_count_o = corr_count_q;

endmodule

// ==== logic/ecc_mem_top.sv ====
// Top level of the SECDED memory: Wishbone front end, encoder, RAM model and decoder
`timescale 1ns/1ps
`include "ecc_mem_consts.svh"

module ecc_mem_top (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      cyc_i,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic [`ECC_ADDR_W-1:0]    adr_i,
  input  logic [`ECC_DATA_W-1:0]    dat_i,
  output logic [`ECC_DATA_W-1:0]    dat_o,
  output logic                      ack_o,
  output logic                      err_o,
  output ecc_mem_pkg::ecc_status_e  ecc_status_o,
  output logic [15:0]               corr_count_o,
  input  logic [`ECC_CODE_W-1:0]    inject_mask_i
);

  // Front end to encoder carries data only, encoder to RAM adds the codeword
  mem_req_if fe_req ();
  mem_req_if ram_req ();

  logic                     rd_valid;
  logic [`ECC_CODE_W-1:0]   rd_code;
  logic                     rsp_valid;
  logic [`ECC_DATA_W-1:0]   rsp_data;
  ecc_mem_pkg::ecc_status_e rsp_status;

  wb_mem_frontend u_frontend (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cyc_i        (cyc_i),
    .stb_i        (stb_i),
    .we_i         (we_i),
    .adr_i        (adr_i),
    .dat_i        (dat_i),
    .dat_o        (dat_o),
    .ack_o        (ack_o),
    .err_o        (err_o),
    .ecc_status_o (ecc_status_o),
    .req          (fe_req.src),
    .rsp_valid_i  (rsp_valid),
    .rsp_data_i   (rsp_data),
    .rsp_status_i (rsp_status)
  );

  secded_encoder u_encoder (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .up       (fe_req.dst),
    .down     (ram_req.src)
  );

  // Fault injection enters here from the top-level port
  badbit_ram_1p u_ram (
    .clk_i         (clk_i),
    .req           (ram_req.dst),
    .inject_mask_i (inject_mask_i),
    .rd_valid_o    (rd_valid),
    .rd_code_o     (rd_code)
  );

  secded_decoder u_decoder (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .rd_valid_i   (rd_valid),
    .rd_code_i    (rd_code),
    .rsp_valid_o  (rsp_valid),
    .rsp_data_o   (rsp_data),
    .rsp_status_o (rsp_status),
    .corr_count_o (corr_count_o)
  );

endmodule

// ==== bench/ecc_mem_assertions.sv ====
// Concurrent Wishbone protocol and latency checks bound into the ECC memory top level
`timescale 1ns/1ps

module ecc_mem_assertions (
  input logic clk_i,
  input logic arst_n_i,
  input logic cyc_i,
  input logic stb_i,
  input logic we_i,
  input logic ack_o,
  input logic err_o
);

  logic strobe;
  logic rsp;
  // Goes high for good once any property below has fired
  logic failed = 1'b0;

  assign strobe = cyc_i && stb_i;
  assign rsp    = ack_o || err_o;

  // Only one kind of response per transaction
  rsp_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(ack_o && err_o)) else begin
      failed = 1'b1;
      $error("ack_o and err_o high together");
    end

  // A response is a single-cycle pulse
  rsp_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp |=> !rsp) else begin
      failed = 1'b1;
      $error("response held longer than one cycle");
    end

  rsp_in_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp |-> strobe) else begin
      failed = 1'b1;
      $error("response outside cyc_i and stb_i");
    end

  // Edge 0 is where the idle front end first sees the strobe
  write_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ($rose(strobe) && we_i) |-> !ack_o ##1 !ack_o ##1 !ack_o ##1 ack_o)
    else begin
      failed = 1'b1;
      $error("write ack not at the third edge");
    end

  read_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ($rose(strobe) && !we_i) |-> !rsp ##1 !rsp ##1 !rsp ##1 !rsp ##1 rsp)
    else begin
      failed = 1'b1;
      $error("read response not at the fourth edge");
    end

endmodule

// ==== bench/ecc_mem_tb.sv ====
// Testbench for the SECDED memory: clock, reset, LCG stimulus, reference model, checks, watchdog
`timescale 1ns/1ps
`include "ecc_mem_consts.svh"

module ecc_mem_tb;

  localparam int NumRandom = 300;
  // Every random step is at most two bus cycles, each at most six clocks long
  localparam int MaxTxn = `ECC_DEPTH + 2 * NumRandom;
  localparam int TimeoutCycles = MaxTxn * 6 + 200;

  logic                     clk_i = 1'b0;
  logic                     arst_n_i;
  logic                     cyc_i;
  logic                     stb_i;
  logic                     we_i;
  logic [`ECC_ADDR_W-1:0]   adr_i;
  logic [`ECC_DATA_W-1:0]   dat_i;
  logic [`ECC_DATA_W-1:0]   dat_o;
  logic                     ack_o;
  logic                     err_o;
  ecc_mem_pkg::ecc_status_e ecc_status_o;
  logic [15:0]              corr_count_o;
  logic [`ECC_CODE_W-1:0]   inject_mask_i;

  // Reference contents of the array and the expected correction count
  logic [`ECC_DATA_W-1:0]   model_mem [`ECC_DEPTH];
  logic [15:0]              model_corr;
  logic [31:0]              lcg_state;

  ecc_mem_top UUT (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .cyc_i         (cyc_i),
    .stb_i         (stb_i),
    .we_i          (we_i),
    .adr_i         (adr_i),
    .dat_i         (dat_i),
    .dat_o         (dat_o),
    .ack_o         (ack_o),
    .err_o         (err_o),
    .ecc_status_o  (ecc_status_o),
    .corr_count_o  (corr_count_o),
    .inject_mask_i (inject_mask_i)
  );

  bind ecc_mem_top ecc_mem_assertions u_assertions (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .cyc_i    (cyc_i),
    .stb_i    (stb_i),
    .we_i     (we_i),
    .ack_o    (ack_o),
    .err_o    (err_o)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Zero flips read clean, one flip is repaired, two flips are only detected
  function automatic ecc_mem_pkg::ecc_status_e expected_status(input logic [`ECC_CODE_W-1:0] m);
    if ($countones(m) == 0) begin
      return ecc_mem_pkg::ECC_OK;
    end else if ($countones(m) == 1) begin
      return ecc_mem_pkg::ECC_CORRECTED;
    end
    return ecc_mem_pkg::ECC_UNCORRECTABLE;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("mismatch at time %0t: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  // One Wishbone classic cycle, cycles counts clock edges from strobe up to the response edge
  task automatic bus_cycle(input logic write, input logic [`ECC_ADDR_W-1:0] addr,
                           input logic [`ECC_DATA_W-1:0] data,
                           input logic [`ECC_CODE_W-1:0] mask,
                           output logic [`ECC_DATA_W-1:0] rdata,
                           output ecc_mem_pkg::ecc_status_e status,
                           output logic got_err, output int cycles);
    logic done;
    done   = 1'b0;
    cycles = 0;
    @(posedge clk_i);
    cyc_i         <= 1'b1;
    stb_i         <= 1'b1;
    we_i          <= write;
    adr_i         <= addr;
    dat_i         <= data;
    inject_mask_i <= mask;
    // Outputs are sampled on the falling edge, away from the register updates
    while (!done) begin
      @(negedge clk_i);
      if (ack_o || err_o) begin
        done    = 1'b1;
        rdata   = dat_o;
        status  = ecc_status_o;
        got_err = err_o;
        assert (!(ack_o && err_o)) else report_mismatch("ack_o and err_o both high");
      end else begin
        cycles++;
        if (cycles > 10) begin
          report_failure("The DUT gave no response within 10 cycles of the strobe");
        end
      end
    end
    @(posedge clk_i);
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
    // A second response for the same cycle would show up here
    @(negedge clk_i);
    assert (!(ack_o || err_o)) else report_mismatch("extra response after the first one");
  endtask

  task automatic write_word(input logic [`ECC_ADDR_W-1:0] addr,
                            input logic [`ECC_DATA_W-1:0] data);
    logic [`ECC_DATA_W-1:0]   rdata;
    ecc_mem_pkg::ecc_status_e status;
    logic                     got_err;
    int                       cycles;
    bus_cycle(1'b1, addr, data, '0, rdata, status, got_err, cycles);
    assert (cycles == 3) else report_mismatch($sformatf("write took %0d cycles", cycles));
    assert (!got_err) else report_mismatch($sformatf("write to %0h ended with err_o", addr));
    model_mem[addr] = data;
  endtask

  task automatic read_word(input logic [`ECC_ADDR_W-1:0] addr,
                           input logic [`ECC_CODE_W-1:0] mask);
    logic [`ECC_DATA_W-1:0]   rdata;
    ecc_mem_pkg::ecc_status_e status;
    ecc_mem_pkg::ecc_status_e exp_status;
    logic                     got_err;
    int                       cycles;
    exp_status = expected_status(mask);
    bus_cycle(1'b0, addr, '0, mask, rdata, status, got_err, cycles);
    if (exp_status == ecc_mem_pkg::ECC_CORRECTED && model_corr != 16'hffff) begin
      model_corr = model_corr + 16'd1;
    end
    assert (cycles == 4) else report_mismatch($sformatf("read took %0d cycles", cycles));
    assert (got_err == (exp_status == ecc_mem_pkg::ECC_UNCORRECTABLE))
      else report_mismatch($sformatf("read %0h mask %h err_o %0b", addr, mask, got_err));
    assert (status == exp_status)
      else report_mismatch($sformatf("read %0h mask %h status %0d expected %0d",
                                     addr, mask, status, exp_status));
    // Data is undefined on err_o
    if (!got_err) begin
      assert (rdata == model_mem[addr])
        else report_mismatch($sformatf("read %0h data %h expected %h",
                                       addr, rdata, model_mem[addr]));
    end
    assert (corr_count_o == model_corr)
      else report_mismatch($sformatf("corr count %0d expected %0d", corr_count_o, model_corr));
  endtask

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    report_failure("Watchdog timeout, the tests did not finish in time");
  end

  // The bound protocol checker raises its flag as soon as one of its properties fires
  always @(negedge clk_i) begin
    if (UUT.u_assertions.failed) begin
      report_failure("A bound protocol assertion failed");
    end
  end

  initial begin
    logic [31:0]            r;
    int unsigned            pos_a;
    int unsigned            pos_b;
    logic [`ECC_ADDR_W-1:0] addr;
    cyc_i         = 1'b0;
    stb_i         = 1'b0;
    we_i          = 1'b0;
    adr_i         = '0;
    dat_i         = '0;
    inject_mask_i = '0;
    arst_n_i      = 1'b0;
    lcg_state     = 32'h3067;
    model_corr    = '0;
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    assert (!ack_o && !err_o && corr_count_o == 16'd0)
      else report_mismatch("outputs not cleared by reset");

    // Fill the whole array so no read sees uninitialized contents
    for (int a = 0; a < `ECC_DEPTH; a++) begin
      write_word(a[`ECC_ADDR_W-1:0], next_rand());
    end

    for (int i = 0; i < NumRandom; i++) begin
      r     = next_rand();
      addr  = r[23:16];
      pos_a = next_rand() % 32'd39;
      pos_b = (pos_a + 1 + next_rand() % 32'd38) % 32'd39;
      case (r[31:30])
        2'd0: write_word(addr, next_rand());
        2'd1: read_word(addr, '0);
        // Injected reads are followed by a clean one to show the array kept its word
        2'd2: begin
          read_word(addr, 39'd1 << pos_a);
          read_word(addr, '0);
        end
        2'd3: begin
          read_word(addr, (39'd1 << pos_a) | (39'd1 << pos_b));
          read_word(addr, '0);
        end
      endcase
    end

    // Let the one-cycle pulse property see the edge after the last response
    repeat (2) @(negedge clk_i);
    if (!UUT.u_assertions.failed) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      report_failure("A bound protocol assertion failed");
    end
  end

endmodule

// ==== ecc_mem.f ====
+incdir+logic
logic/ecc_mem_pkg.sv
logic/mem_req_if.sv
logic/wb_mem_frontend.sv
logic/secded_encoder.sv
logic/badbit_ram_1p.sv
logic/secded_decoder.sv
logic/ecc_mem_top.sv
bench/ecc_mem_assertions.sv
bench/ecc_mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the SECDED memory testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module ecc_mem_tb -f ecc_mem.f -o ecc_mem_sim

output="$(./obj_dir/ecc_mem_sim 2>&1)" || { echo "$output"; echo "Simulation exited with an error"; exit 1; }
echo "$output"

if grep -qx "STATUS: PASS" <<< "$output"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
